// ==== filelist.f ====
+incdir+.
mipsPkg.sv
pcUnit.sv
instrDecode.sv
regFile.sv
aluUnit.sv
memWriteback.sv
mipsCore.sv
mipsTb.sv

// ==== Bender.yml ====
package:
  name: mipsCore

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - mipsPkg.sv
      - pcUnit.sv
      - instrDecode.sv
      - regFile.sv
      - aluUnit.sv
      - memWriteback.sv
      - mipsCore.sv
  - target: test
    include_dirs:
      - .
    files:
      - mipsTb.sv

// ==== mipsTb.sv ====
// testbench for the single-cycle core: memories, reference model, program and assertions
`timescale 1ns/1ps
`include "mipsCfg.svh"
`default_nettype none

module mipsTb
  import mipsPkg::*;
();

  localparam int DmemWords = 1 << `MIPS_DMEM_AW;
  localparam int NumTests  = 6;

  // DUT ports
  logic                     clk;
  logic                     rst;
  logic [31:0]              instr;
  logic [31:0]              instrAddr;
  logic [31:0]              memRdata;
  logic                     memCen;
  logic                     memWen;
  logic [`MIPS_DMEM_AW-1:0] memAddr;
  logic [31:0]              memWdata;
  logic                     rfWe;
  logic [4:0]               rfWaddr;
  logic [31:0]              rfWdata;

  // memories and architectural model
  logic [31:0] imem [64];
  logic [31:0] dmem [DmemWords];
  logic [31:0] fillData [DmemWords];
  logic [31:0] modelMem [DmemWords];
  logic [31:0] modelRegs [32];
  logic [31:0] modelPc;
  int          seed;
  int          errCount;

  // model expectations for the current instruction
  instrU                    curInstr;
  logic [31:0]              rsVal;
  logic [31:0]              rtVal;
  logic [31:0]              immExt;
  logic [31:0]              byteAddr;
  logic [31:0]              pcPlus4;
  logic                     expWe;
  logic [4:0]               expWaddr;
  logic [31:0]              expWdata;
  logic                     expCen;
  logic                     expWen;
  logic [`MIPS_DMEM_AW-1:0] expAddr;
  logic [31:0]              expMemWdata;
  logic [31:0]              expNextPc;

  mipsCore mipsCore_inst (
    .clk(clk), .rst(rst), .instr(instr), .instrAddr(instrAddr), .memRdata(memRdata),
    .memCen(memCen), .memWen(memWen), .memAddr(memAddr), .memWdata(memWdata),
    .rfWe(rfWe), .rfWaddr(rfWaddr), .rfWdata(rfWdata)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ============================================================
  // memories seen by the DUT
  // ============================================================

  // combinational fetch with a nop during reset
  assign instr    = rst ? imem[instrAddr[7:2]] : 32'h0;
  assign memRdata = (!memCen && memWen) ? dmem[memAddr] : 32'h0;

  always @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < DmemWords; i++) begin
        dmem[i] <= fillData[i];
      end
    end else if (!memCen && !memWen) begin
      dmem[memAddr] <= memWdata;
    end
  end

  // ============================================================
  // reference model
  // ============================================================

  always_comb begin
    curInstr    = imem[modelPc[7:2]];
    rsVal       = modelRegs[curInstr.rType.rs];
    rtVal       = modelRegs[curInstr.rType.rt];
    immExt      = {{16{curInstr.iType.imm16[15]}}, curInstr.iType.imm16};
    byteAddr    = rsVal + immExt;
    pcPlus4     = modelPc + 32'd4;
    // defaults give no write, an idle memory and sequential flow
    expWe       = 1'b0;
    expWaddr    = curInstr.rType.rd;
    expWdata    = 32'h0;
    expCen      = 1'b1;
    expWen      = 1'b1;
    expAddr     = byteAddr[`MIPS_DMEM_AW+1:2];
    expMemWdata = rtVal;
    expNextPc   = pcPlus4;
    case (curInstr.rType.opcode)
      OP_RTYPE: begin
        expWe = 1'b1;
        case (curInstr.rType.funct)
          FN_ADD: expWdata = rsVal + rtVal;
          FN_SUB: expWdata = rsVal - rtVal;
          FN_AND: expWdata = rsVal & rtVal;
          FN_OR:  expWdata = rsVal | rtVal;
          // unsigned compare
          FN_SLT: expWdata = {31'd0, rsVal < rtVal};
          FN_JR: begin
            expWe     = 1'b0;
            expNextPc = rsVal;
          end
          default: expWe = 1'b0;
        endcase
      end
      OP_LW: begin
        expWe    = 1'b1;
        expWaddr = curInstr.iType.rt;
        expWdata = modelMem[expAddr];
        expCen   = 1'b0;
      end
      OP_SW: begin
        expCen = 1'b0;
        expWen = 1'b0;
      end
      OP_BEQ: begin
        if (rsVal == rtVal) begin
          expNextPc = pcPlus4 + {immExt[29:0], 2'b00};
        end
      end
      OP_J:   expNextPc = {pcPlus4[31:28], curInstr.jType.target26, 2'b00};
      OP_JAL: begin
        expNextPc = {pcPlus4[31:28], curInstr.jType.target26, 2'b00};
        expWe     = 1'b1;
        expWaddr  = 5'd31;
        // link address skips the delay-slot word
        expWdata  = modelPc + 32'd8;
      end
      default: expWe = 1'b0;
    endcase
  end

  // architectural state commits on the same edge as the DUT
  always @(posedge clk) begin
    if (!rst) begin
      modelPc <= `MIPS_RESET_PC;
      for (int i = 0; i < 32; i++) begin
        modelRegs[i] <= 32'h0;
      end
      for (int i = 0; i < DmemWords; i++) begin
        modelMem[i] <= fillData[i];
      end
    end else begin
      if (expWe && (expWaddr != 5'd0)) begin
        modelRegs[expWaddr] <= expWdata;
      end
      if (!expCen && !expWen) begin
        modelMem[expAddr] <= expMemWdata;
      end
      modelPc <= expNextPc;
    end
  end

  // ============================================================
  // checks
  // ============================================================

  pcCheck: assert property (@(posedge clk) rst |-> (instrAddr == modelPc))
    else begin
      errCount++;
      $display("Mismatch instrAddr expected 0x%08h got 0x%08h", $sampled(modelPc),
               $sampled(instrAddr));
    end

  weCheck: assert property (@(posedge clk) rst |-> (rfWe == expWe))
    else begin
      errCount++;
      $display("Mismatch rfWe expected 0x%0h got 0x%0h", $sampled(expWe), $sampled(rfWe));
    end

  waddrCheck: assert property (@(posedge clk) (rst && expWe) |-> (rfWaddr == expWaddr))
    else begin
      errCount++;
      $display("Mismatch rfWaddr expected 0x%02h got 0x%02h", $sampled(expWaddr),
               $sampled(rfWaddr));
    end

  wdataCheck: assert property (@(posedge clk) (rst && expWe) |-> (rfWdata == expWdata))
    else begin
      errCount++;
      $display("Mismatch rfWdata expected 0x%08h got 0x%08h", $sampled(expWdata),
               $sampled(rfWdata));
    end

  cenCheck: assert property (@(posedge clk) rst |-> (memCen == expCen))
    else begin
      errCount++;
      $display("Mismatch memCen expected 0x%0h got 0x%0h", $sampled(expCen), $sampled(memCen));
    end

  // access type and word address whenever the chip is enabled
  accessCheck: assert property (@(posedge clk) (rst && !expCen) |->
    ((memWen == expWen) && (memAddr == expAddr)))
    else begin
      errCount++;
      $display("Mismatch memWen/memAddr expected 0x%0h/0x%02h got 0x%0h/0x%02h",
               $sampled(expWen), $sampled(expAddr), $sampled(memWen), $sampled(memAddr));
    end

  storeCheck: assert property (@(posedge clk) (rst && !expCen && !expWen) |->
    (memWdata == expMemWdata))
    else begin
      errCount++;
      $display("Mismatch memWdata expected 0x%08h got 0x%08h", $sampled(expMemWdata),
               $sampled(memWdata));
    end

  // nothing leaves the core while reset is held
  resetQuiet: assert property (@(posedge clk) !rst |-> (memCen && memWen && !rfWe))
    else begin
      errCount++;
      $display("memory or register write active during reset");
    end

  // ============================================================
  // program
  // ============================================================

  function automatic logic [31:0] rFormat(functE fn, logic [4:0] rs, logic [4:0] rt,
                                          logic [4:0] rd);
    instrU w;
    w.rType = '{opcode: OP_RTYPE, rs: rs, rt: rt, rd: rd, shamt: 5'd0, funct: fn};
    return w;
  endfunction

  function automatic logic [31:0] iFormat(opcodeE op, logic [4:0] rs, logic [4:0] rt,
                                          logic [15:0] imm);
    instrU w;
    w.iType = '{opcode: op, rs: rs, rt: rt, imm16: imm};
    return w;
  endfunction

  function automatic logic [31:0] jFormat(opcodeE op, logic [25:0] target);
    instrU w;
    w.jType = '{opcode: op, target26: target};
    return w;
  endfunction

  task automatic loadProgram();
    for (int i = 0; i < 64; i++) begin
      imem[i] = 32'h0;
    end
    // loads with one from the top word
    imem[0]  = iFormat(OP_LW, 5'd0, 5'd1, 16'h0000);
    imem[1]  = iFormat(OP_LW, 5'd0, 5'd2, 16'h0004);
    imem[2]  = iFormat(OP_LW, 5'd0, 5'd3, 16'h01fc);
    imem[3]  = iFormat(OP_LW, 5'd0, 5'd4, 16'h0040);
    // arithmetic
    imem[4]  = rFormat(FN_ADD, 5'd1, 5'd2, 5'd5);
    imem[5]  = rFormat(FN_SUB, 5'd1, 5'd2, 5'd6);
    imem[6]  = rFormat(FN_AND, 5'd3, 5'd4, 5'd7);
    imem[7]  = rFormat(FN_OR,  5'd3, 5'd4, 5'd8);
    imem[8]  = rFormat(FN_SLT, 5'd1, 5'd2, 5'd9);
    imem[9]  = rFormat(FN_SLT, 5'd2, 5'd1, 5'd10);
    // stores and read-back with the last pair off a random base register
    imem[10] = iFormat(OP_SW, 5'd0, 5'd5, 16'h0020);
    imem[11] = iFormat(OP_SW, 5'd0, 5'd6, 16'h0024);
    imem[12] = iFormat(OP_LW, 5'd0, 5'd11, 16'h0020);
    imem[13] = iFormat(OP_LW, 5'd0, 5'd12, 16'h0024);
    imem[14] = iFormat(OP_SW, 5'd3, 5'd1, 16'h0010);
    imem[15] = iFormat(OP_LW, 5'd3, 5'd13, 16'h0010);
    // taken beq skips word 17 before a not-taken one
    imem[16] = iFormat(OP_BEQ, 5'd11, 5'd5, 16'h0001);
    imem[17] = rFormat(FN_ADD, 5'd1, 5'd1, 5'd16);
    imem[18] = iFormat(OP_BEQ, 5'd1, 5'd2, 16'h0005);
    // j over two words then jal into word 40 and jr back to pc plus 8
    imem[19] = jFormat(OP_J, 26'd22);
    imem[20] = rFormat(FN_ADD, 5'd1, 5'd1, 5'd17);
    imem[21] = rFormat(FN_ADD, 5'd1, 5'd1, 5'd18);
    imem[22] = jFormat(OP_JAL, 26'd40);
    imem[23] = rFormat(FN_ADD, 5'd1, 5'd1, 5'd19);
    imem[24] = rFormat(FN_ADD, 5'd31, 5'd0, 5'd20);
    imem[40] = rFormat(FN_JR, 5'd31, 5'd0, 5'd0);
    // write to $zero and read it back
    imem[25] = rFormat(FN_ADD, 5'd1, 5'd2, 5'd0);
    imem[26] = rFormat(FN_ADD, 5'd0, 5'd0, 5'd21);
    // parked
    imem[27] = jFormat(OP_J, 26'd27);
  endtask

  task automatic waitForPc(input logic [31:0] target, output bit timedOut);
    int cycles;
    cycles   = 0;
    timedOut = 1'b0;
    while ((instrAddr !== target) && !timedOut) begin
      @(negedge clk);
      cycles++;
      if (cycles > 50) begin
        timedOut = 1'b1;
      end
    end
  endtask

  // ============================================================
  // sequence
  // ============================================================

  initial begin
    string testName [NumTests];
    int    testEnd [NumTests];
    int    errBefore;
    int    okTests;
    int    failedTests;
    bit    timedOut;

    testName = '{"loads", "arithmetic", "stores", "branches", "jumps", "register zero"};
    testEnd  = '{4, 10, 16, 19, 25, 27};
    rst         = 1'b0;
    errCount    = 0;
    okTests     = 0;
    failedTests = 0;
    seed        = 32'h12e7_cc5b;
    for (int i = 0; i < DmemWords; i++) begin
      fillData[i] = $random(seed);
    end
    loadProgram();

    repeat (4) @(posedge clk);
    rst <= 1'b1;

    for (int t = 0; t < NumTests; t++) begin
      errBefore = errCount;
      waitForPc(`MIPS_RESET_PC + 32'(4 * testEnd[t]), timedOut);
      if (timedOut) begin
        failedTests++;
        $display("test %s: pc never reached 0x%08h", testName[t], 4 * testEnd[t]);
        break;
      end else if (errCount != errBefore) begin
        failedTests++;
        $display("test %s: failed with %0d errors", testName[t], errCount - errBefore);
      end else begin
        okTests++;
        $display("test %s: ok", testName[t]);
      end
    end

    $display("tests ok %0d, failed %0d, check errors %0d", okTests, failedTests, errCount);
    if ((failedTests == 0) && (errCount == 0)) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== mipsCore.sv ====
// single-cycle core top level, connects fetch, decode, registers, ALU and memory side
`timescale 1ns/1ps
`include "mipsCfg.svh"
`default_nettype none

module mipsCore
  import mipsPkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic [31:0]              instr,
  output logic [31:0]              instrAddr,
  input  logic [31:0]              memRdata,
  output logic                     memCen,
  output logic                     memWen,
  output logic [`MIPS_DMEM_AW-1:0] memAddr,
  output logic [31:0]              memWdata,
  output logic                     rfWe,
  output logic [4:0]               rfWaddr,
  output logic [31:0]              rfWdata
);

  // ============================================================
  // internal nets
  // ============================================================

  instrU       instrWord;

  // decoder outputs
  logic        regDst;
  logic        aluSrc;
  logic        memToReg;
  logic        regWrite;
  logic        memRead;
  logic        memWrite;
  logic        branch;
  logic        jump;
  logic        jal;
  logic        jr;
  aluOpE       aluOp;

  // datapath
  logic [31:0] rsData;
  logic [31:0] rtData;
  logic [31:0] aluResult;
  logic [31:0] branchOffset;
  logic        aluZero;
  logic [31:0] pcPlus8;

  // register field view of the fetched word
  assign instrWord = instr;

  // ============================================================
  // input side
  // ============================================================

  pcUnit pcUnit_inst (
    .clk(clk), .rst(rst), .instr(instr), .jump(jump), .jr(jr), .branch(branch),
    .aluZero(aluZero), .branchOffset(branchOffset), .rsData(rsData),
    .pc(instrAddr), .pcPlus8(pcPlus8)
  );

  instrDecode instrDecode_inst (
    .instr(instr), .regDst(regDst), .aluSrc(aluSrc), .memToReg(memToReg),
    .regWrite(regWrite), .memRead(memRead), .memWrite(memWrite), .branch(branch),
    .jump(jump), .jal(jal), .jr(jr), .aluOp(aluOp)
  );

  // ============================================================
  // processing
  // ============================================================

  // write port fed from the write-back select
  regFile regFile_inst (
    .clk(clk), .rst(rst), .we(rfWe), .rsAddr(instrWord.rType.rs),
    .rtAddr(instrWord.rType.rt), .wAddr(rfWaddr), .wData(rfWdata),
    .rsData(rsData), .rtData(rtData)
  );

  aluUnit aluUnit_inst (
    .instr(instr), .aluSrc(aluSrc), .aluOp(aluOp), .rsData(rsData), .rtData(rtData),
    .aluResult(aluResult), .branchOffset(branchOffset), .aluZero(aluZero)
  );

  // ============================================================
  // output side
  // ============================================================

  // write-back also goes straight out for observation
  memWriteback memWriteback_inst (
    .instr(instr), .regDst(regDst), .memToReg(memToReg), .regWrite(regWrite),
    .memRead(memRead), .memWrite(memWrite), .jal(jal), .aluResult(aluResult),
    .rtData(rtData), .memRdata(memRdata), .pcPlus8(pcPlus8), .memCen(memCen),
    .memWen(memWen), .memAddr(memAddr), .memWdata(memWdata), .wbData(rfWdata),
    .wbAddr(rfWaddr), .wbEn(rfWe)
  );

endmodule

`default_nettype wire

// ==== memWriteback.sv ====
// data SRAM port drive and register write-back select for the core
`timescale 1ns/1ps
`include "mipsCfg.svh"
`default_nettype none

module memWriteback
  import mipsPkg::*;
(
  input  instrU                      instr,
  input  logic                       regDst,
  input  logic                       memToReg,
  input  logic                       regWrite,
  input  logic                       memRead,
  input  logic                       memWrite,
  input  logic                       jal,
  input  logic [31:0]                aluResult,
  input  logic [31:0]                rtData,
  input  logic [31:0]                memRdata,
  input  logic [31:0]                pcPlus8,
  output logic                       memCen,
  output logic                       memWen,
  output logic [`MIPS_DMEM_AW-1:0]   memAddr,
  output logic [31:0]                memWdata,
  output logic [31:0]                wbData,
  output logic [4:0]                 wbAddr,
  output logic                       wbEn
);

  // ============================================================
  // data memory port
  // ============================================================

  // both strobes active low
  // chip enable only for lw and sw
  assign memCen   = ~(memRead | memWrite);
  assign memWen   = ~memWrite;
  // byte address to word address
  assign memAddr  = aluResult[`MIPS_DMEM_AW+1:2];
  assign memWdata = rtData;

  // ============================================================
  // write back
  // ============================================================

  // link register wins over rd and rt
  always_comb begin
    if (jal) begin
      wbAddr = 5'd31;
      wbData = pcPlus8;
    end else begin
      wbAddr = regDst ? instr.rType.rd : instr.rType.rt;
      wbData = memToReg ? memRdata : aluResult;
    end
  end

  assign wbEn = regWrite;

endmodule

`default_nettype wire

// ==== aluUnit.sv ====
// execute stage: operand select, ALU and branch offset, fully combinational
`timescale 1ns/1ps
`default_nettype none

module aluUnit
  import mipsPkg::*;
(
  input  instrU       instr,
  input  logic        aluSrc,
  input  aluOpE       aluOp,
  input  logic [31:0] rsData,
  input  logic [31:0] rtData,
  output logic [31:0] aluResult,
  output logic [31:0] branchOffset,
  output logic        aluZero
);

  logic [31:0] immExt;
  logic [31:0] opB;

  // ============================================================
  // operands
  // ============================================================

  // sign extension of the 16-bit field
  assign immExt = {{16{instr.iType.imm16[15]}}, instr.iType.imm16};
  // immediate for lw and sw
  assign opB    = aluSrc ? immExt : rtData;

  // word offset to byte offset
  assign branchOffset = {immExt[29:0], 2'b00};

  // ============================================================
  // operation
  // ============================================================

  always_comb begin
    case (aluOp)
      ALU_ADD: aluResult = rsData + opB;
      ALU_SUB: aluResult = rsData - opB;
      ALU_AND: aluResult = rsData & opB;
      ALU_OR:  aluResult = rsData | opB;
      // unsigned compare
      ALU_SLT: aluResult = (rsData < opB) ? 32'd1 : 32'd0;
      default: aluResult = 32'd0;
    endcase
  end

  // beq qualifies this with branch
  assign aluZero = (aluResult == 32'd0);

endmodule

`default_nettype wire

// ==== regFile.sv ====
// 32-entry general purpose register file, two reads and one write per cycle
`timescale 1ns/1ps
`default_nettype none

module regFile (
  input  logic        clk,
  input  logic        rst,
  input  logic        we,
  input  logic [4:0]  rsAddr,
  input  logic [4:0]  rtAddr,
  input  logic [4:0]  wAddr,
  input  logic [31:0] wData,
  output logic [31:0] rsData,
  output logic [31:0] rtData
);

  logic [31:0] regs [32];

  // ============================================================
  // write port
  // ============================================================

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      // whole file cleared
      for (int idx = 0; idx < 32; idx++) begin
        regs[idx] <= 32'd0;
      end
    end else if (we && (wAddr != 5'd0)) begin
      // $zero never written
      regs[wAddr] <= wData;
    end
  end

  // ============================================================
  // read ports
  // ============================================================

  // no bypass of a same-cycle write
  assign rsData = regs[rsAddr];
  assign rtData = regs[rtAddr];

  // holds only if no write ever reached entry zero
  zeroReads: assert property (@(posedge clk) disable iff (!rst)
    ((rsAddr == 5'd0) |-> (rsData == 32'd0)) and ((rtAddr == 5'd0) |-> (rtData == 32'd0)))
    else $error("register zero read non-zero rs 0x%08h rt 0x%08h", rsData, rtData);

endmodule

`default_nettype wire

// ==== instrDecode.sv ====
// main control and ALU control decoder, one combinational stage in the core
`timescale 1ns/1ps
`default_nettype none

module instrDecode
  import mipsPkg::*;
(
  input  instrU instr,
  output logic  regDst,
  output logic  aluSrc,
  output logic  memToReg,
  output logic  regWrite,
  output logic  memRead,
  output logic  memWrite,
  output logic  branch,
  output logic  jump,
  output logic  jal,
  output logic  jr,
  output aluOpE aluOp
);

  opcodeE opcode;
  functE  funct;

  // enum views of the two selector fields
  assign opcode = opcodeE'(instr.rType.opcode);
  assign funct  = functE'(instr.rType.funct);

  // ============================================================
  // control table
  // ============================================================

  always_comb begin
    // idle defaults
    // unknown encodings keep these
    regDst   = 1'b0;
    aluSrc   = 1'b0;
    memToReg = 1'b0;
    regWrite = 1'b0;
    memRead  = 1'b0;
    memWrite = 1'b0;
    branch   = 1'b0;
    jump     = 1'b0;
    jal      = 1'b0;
    jr       = 1'b0;
    aluOp    = ALU_INVALID;

    case (opcode)
      OP_RTYPE: begin
        regDst = 1'b1;
        // funct picks the operation
        case (funct)
          FN_ADD: begin
            regWrite = 1'b1;
            aluOp    = ALU_ADD;
          end
          FN_SUB: begin
            regWrite = 1'b1;
            aluOp    = ALU_SUB;
          end
          FN_AND: begin
            regWrite = 1'b1;
            aluOp    = ALU_AND;
          end
          FN_OR: begin
            regWrite = 1'b1;
            aluOp    = ALU_OR;
          end
          FN_SLT: begin
            regWrite = 1'b1;
            aluOp    = ALU_SLT;
          end
          // no write back for jr
          FN_JR:   jr = 1'b1;
          default: regDst = 1'b0;
        endcase
      end
      OP_LW: begin
        // base plus offset
        aluSrc   = 1'b1;
        memToReg = 1'b1;
        regWrite = 1'b1;
        memRead  = 1'b1;
        aluOp    = ALU_ADD;
      end
      OP_SW: begin
        aluSrc   = 1'b1;
        memWrite = 1'b1;
        aluOp    = ALU_ADD;
      end
      OP_BEQ: begin
        // equality through subtract
        branch = 1'b1;
        aluOp  = ALU_SUB;
      end
      OP_J:    jump = 1'b1;
      OP_JAL: begin
        jump     = 1'b1;
        jal      = 1'b1;
        regWrite = 1'b1;
      end
      default: aluOp = ALU_INVALID;
    endcase
  end

  // one memory access type per instruction
  memExclusive: assert final (!(memRead && memWrite))
    else $error("memRead and memWrite both set for 0x%08h", instr);

endmodule

`default_nettype wire

// ==== pcUnit.sv ====
// program counter and next-pc selection, instantiated once in the core top level
`timescale 1ns/1ps
`include "mipsCfg.svh"
`default_nettype none

module pcUnit
  import mipsPkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  instrU       instr,
  input  logic        jump,
  input  logic        jr,
  input  logic        branch,
  input  logic        aluZero,
  input  logic [31:0] branchOffset,
  input  logic [31:0] rsData,
  output logic [31:0] pc,
  output logic [31:0] pcPlus8
);

  logic [31:0] pcPlus4;
  logic [31:0] jumpTarget;
  logic [31:0] branchTarget;
  logic [31:0] pcNext;
  logic        branchTaken;

  // ============================================================
  // candidate targets
  // ============================================================

  assign pcPlus4 = pc + 32'd4;
  // return address for jal
  assign pcPlus8 = pc + 32'd8;

  // region bits come from the delay-slot address
  assign jumpTarget   = {pcPlus4[31:28], instr.jType.target26, 2'b00};
  assign branchTarget = pcPlus4 + branchOffset;
  // beq only, zero from the subtract
  assign branchTaken  = branch & aluZero;

  // jump beats branch beats jr
  always_comb begin
    if (jump) begin
      pcNext = jumpTarget;
    end else if (branchTaken) begin
      pcNext = branchTarget;
    end else if (jr) begin
      // full register value
      pcNext = rsData;
    end else begin
      pcNext = pcPlus4;
    end
  end

  // ============================================================
  // pc register
  // ============================================================

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= `MIPS_RESET_PC;
    end else begin
      pc <= pcNext;
    end
  end

  // misaligned jr source or offset would show up here
  pcAligned: assert property (@(posedge clk) disable iff (!rst) pc[1:0] == 2'b00)
    else $error("pc not word aligned 0x%08h", pc);

endmodule

`default_nettype wire

// ==== mipsPkg.sv ====
// shared encodings and the instruction-word view, imported by the core blocks and testbench
`default_nettype none

package mipsPkg;

  // ============================================================
  // instruction encodings
  // ============================================================

  // primary opcode field
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_JAL   = 6'h03,
    OP_BEQ   = 6'h04,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2b
  } opcodeE;

  // funct field, only meaningful for r-type
  typedef enum logic [5:0] {
    FN_JR  = 6'h08,
    FN_ADD = 6'h20,
    FN_SUB = 6'h22,
    FN_AND = 6'h24,
    FN_OR  = 6'h25,
    FN_SLT = 6'h2a
  } functE;

  // internal ALU operation select
  typedef enum logic [2:0] {
    ALU_ADD     = 3'd0,
    ALU_SUB     = 3'd1,
    ALU_AND     = 3'd2,
    ALU_OR      = 3'd3,
    ALU_SLT     = 3'd4,
    ALU_INVALID = 3'd7
  } aluOpE;

  // ============================================================
  // instruction formats
  // ============================================================

  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } rTypeS;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm16;
  } iTypeS;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] target26;
  } jTypeS;

  // one 32-bit word, three decodings
  typedef union packed {
    rTypeS rType;
    iTypeS iType;
    jTypeS jType;
  } instrU;

endpackage

`default_nettype wire

// ==== mipsCfg.svh ====
// core-wide constants, included by the pc, memory-side and testbench sources
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// ============================================================
// fetch
// ============================================================

// first fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

// ============================================================
// data memory
// ============================================================

// word address width of the data SRAM port
`define MIPS_DMEM_AW 7

`endif
